// ==== hbm_pair_merge.f ====
+incdir+rtl
rtl/hbm_merge_pkg.sv
rtl/param_capture.sv
rtl/channel_fifo.sv
rtl/pair_joiner.sv
rtl/hbm_pair_merge.sv
testbench/tb_hbm_pair_merge.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_hbm_pair_merge
FILELIST  = hbm_pair_merge.f
OBJ_DIR   = obj_dir
PASS_MSG  = RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_hbm_pair_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hbm_merge_cfg.svh"

module tb_hbm_pair_merge
    import hbm_merge_pkg::*;
();

    localparam int NPAIR = `HBM_NUM_PAIRS;
    localparam int NCH   = 2 * NPAIR;
    localparam int NROWS = 5;

    logic                   hbm_clk = 1'b0;
    logic                   hbm_rstn;
    logic                   params_valid;
    mlw_params_t            params;
    rd_beat_t               rd_beat [NCH];
    logic [NCH-1:0]         rd_ready;
    merged_word_t           word [NPAIR];
    logic [NPAIR-1:0]       credit;
    logic [NPAIR-1:0]       job_done;

    ////////////////////
    // job table: byte length, beat density %, credit density %, credit stall cycles
    int tbl_len   [NROWS] = '{2048, 4096, 12288, 1024, 8192};
    int tbl_beat  [NROWS] = '{100, 40, 90, 25, 70};
    int tbl_cred  [NROWS] = '{100, 60, 50, 20, 80};
    int tbl_stall [NROWS] = '{0, 0, 200, 40, 0};

    logic [`HBM_BEAT_W-1:0] sb_q [NCH][$];      // accepted beats per channel
    int          sent [NCH];                    // beats accepted this job
    bit          hold [NCH];                    // beat waiting on ready
    bit          ready_low_seen [NCH];
    int          words_rx [NPAIR];
    int          outstanding [NPAIR];           // words not yet credited back
    bit          done_seen [NPAIR];
    int          job_words;
    int          job_id;
    int          err_value = 0;
    int          err_other = 0;
    int          cycle_cnt = 0;
    logic [31:0] rng_state = 32'h101aa58c;

    always #2 hbm_clk = ~hbm_clk;               // 4 ns period

    hbm_pair_merge i_hbm_pair_merge (
        .hbm_clk        (hbm_clk),
        .hbm_rstn       (hbm_rstn),
        .params_valid_i (params_valid),
        .params_i       (params),
        .rd_beat_i      (rd_beat),
        .rd_ready_o     (rd_ready),
        .word_o         (word),
        .credit_i       (credit),
        .job_done_o     (job_done)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic bit chance(input int pct);
        rng_state = xorshift32(rng_state);
        return (rng_state % 100) < pct;
    endfunction

    // 32b lanes of {channel, lane, job, seq}
    function automatic logic [`HBM_BEAT_W-1:0] make_beat(input int ch, input int job, input int seq);
        logic [`HBM_BEAT_W-1:0] d;
        for (int i = 0; i < `HBM_BEAT_W / 32; i++) begin
            d[i*32 +: 32] = {ch[3:0], 4'(i), job[7:0], seq[15:0]};
        end
        return d;
    endfunction

    task automatic compare_value(input string sig, input logic [`HBM_WORD_W-1:0] got,
                                 input logic [`HBM_WORD_W-1:0] exp);
        assert (got === exp) else begin
            $display("FAILED t=%0t %s got=%0h exp=%0h", $time, sig, got, exp);
            err_value++;
        end
    endtask

    ////////////////////
    // scoreboard and credit bookkeeping, outputs sampled mid cycle
    task automatic check_outputs();
        logic [`HBM_WORD_W-1:0] exp_word;
        bit                     exp_end;
        for (int p = 0; p < NPAIR; p++) begin
            exp_end = 1'b0;
            if (word[p].valid) begin
                words_rx[p]++;
                outstanding[p]++;
                exp_end = (words_rx[p] == job_words);       // len / 64 / 2
                assert (outstanding[p] <= `HBM_CREDITS) else begin
                    $display("pair %0d has %0d words out with no credit back", p, outstanding[p]);
                    err_other++;
                end
                assert (words_rx[p] <= job_words) else begin
                    $display("pair %0d sent a word past the end of job %0d", p, job_id);
                    err_other++;
                end
                assert (sb_q[2*p].size() > 0 && sb_q[2*p+1].size() > 0) else begin
                    $display("pair %0d sent a word with no accepted beats behind it", p);
                    err_other++;
                end
                if (sb_q[2*p].size() > 0 && sb_q[2*p+1].size() > 0) begin
                    exp_word = {sb_q[2*p+1].pop_front(), sb_q[2*p].pop_front()};  // odd, even
                    compare_value($sformatf("word_o[%0d].data", p), word[p].data, exp_word);
                end
                compare_value($sformatf("word_o[%0d].last", p), word[p].last, exp_end);
            end
            compare_value($sformatf("job_done_o[%0d]", p), job_done[p], exp_end);
            if (job_done[p]) begin
                done_seen[p] = 1'b1;
            end
        end
    endtask

    ////////////////////
    // channel models, a beat stays put until ready takes it
    task automatic drive_channels(input int pct);
        int dens;
        for (int c = 0; c < NCH; c++) begin
            dens = (c % 2 == 1) ? pct : pct * 2 / 3 + 10;   // uneven rates in a pair
            if (dens > 100) dens = 100;
            if (!rd_ready[c]) ready_low_seen[c] = 1'b1;
            if (!hold[c]) begin
                rd_beat[c].valid = 1'b0;
                if (sent[c] < job_words && chance(dens)) begin
                    rd_beat[c].valid = 1'b1;
                    rd_beat[c].data  = make_beat(c, job_id, sent[c]);
                end
            end
            // ready is registered, so this is what the next edge sees
            if (rd_beat[c].valid && rd_ready[c]) begin
                sb_q[c].push_back(rd_beat[c].data);
                sent[c]++;
                hold[c] = 1'b0;
            end else begin
                hold[c] = rd_beat[c].valid;
            end
        end
    endtask

    task automatic drive_credits(input int pct, input bit stalled);
        for (int p = 0; p < NPAIR; p++) begin
            credit[p] = 1'b0;
            if (!stalled && outstanding[p] > 0 && chance(pct)) begin
                credit[p] = 1'b1;
                outstanding[p]--;
            end
        end
    endtask

    function automatic bit row_finished();
        bit fin;
        fin = 1'b1;
        for (int p = 0; p < NPAIR; p++) fin &= done_seen[p] && (outstanding[p] == 0);
        for (int c = 0; c < NCH; c++) fin &= (sent[c] == job_words);
        return fin;
    endfunction

    task automatic run_row(input int row);
        int row_cycle;
        job_id    = row + 1;
        job_words = tbl_len[row] / 64 / 2;
        row_cycle = 0;
        for (int c = 0; c < NCH; c++) begin
            sent[c]           = 0;
            hold[c]           = 1'b0;
            ready_low_seen[c] = 1'b0;
        end
        for (int p = 0; p < NPAIR; p++) begin
            words_rx[p]  = 0;
            done_seen[p] = 1'b0;
        end
        do begin
            @(negedge hbm_clk);
            params_valid = (row_cycle == 0);                // one cycle pulse
            params.data_a_length = tbl_len[row];
            params.number_of_epochs = job_id;
            check_outputs();
            drive_channels(tbl_beat[row]);
            drive_credits(tbl_cred[row], row_cycle < tbl_stall[row]);
            row_cycle++;
        end while (!row_finished());
        for (int c = 0; c < NCH; c++) begin
            assert (sb_q[c].size() == 0) else begin
                $display("channel %0d has %0d beats never merged", c, sb_q[c].size());
                err_other++;
            end
            // long stall must fill the fifos past almost-full
            assert (tbl_stall[row] < 100 || ready_low_seen[c]) else begin
                $display("rd_ready_o[%0d] never fell during the credit stall of job %0d",
                         c, job_id);
                err_other++;
            end
        end
    endtask

    ////////////////////
    // watchdog sized from the table
    initial begin : watchdog
        int limit;
        limit = 500;
        for (int r = 0; r < NROWS; r++) limit += (tbl_len[r] / 128) * 8 + tbl_stall[r];
        while (cycle_cnt < limit) begin
            @(posedge hbm_clk);
            cycle_cnt++;
        end
        $display("timeout: no result after %0d cycles", limit);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : main
        hbm_rstn     = 1'b0;
        params_valid = 1'b0;
        params       = '0;
        credit       = '0;
        for (int c = 0; c < NCH; c++) rd_beat[c] = '0;
        repeat (3) @(posedge hbm_clk);
        @(negedge hbm_clk);
        hbm_rstn = 1'b1;
        repeat (4) begin                            // idle after reset
            @(negedge hbm_clk);
            compare_value("rd_ready_o", rd_ready, {NCH{1'b1}});
            for (int p = 0; p < NPAIR; p++) begin
                compare_value($sformatf("word_o[%0d].valid", p), word[p].valid, 1'b0);
                compare_value($sformatf("job_done_o[%0d]", p), job_done[p], 1'b0);
            end
        end
        for (int r = 0; r < NROWS; r++) run_row(r);
        @(negedge hbm_clk);
        $display("errors: value=%0d other=%0d", err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/hbm_pair_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hbm_merge_cfg.svh"

module hbm_pair_merge
    import hbm_merge_pkg::*;
(
    input  logic                        hbm_clk,
    input  logic                        hbm_rstn,

    // parameter word
    input  logic                        params_valid_i,
    input  mlw_params_t                 params_i,

    // hbm read channels
    input  rd_beat_t                    rd_beat_i  [2*`HBM_NUM_PAIRS],
    output logic [2*`HBM_NUM_PAIRS-1:0] rd_ready_o,

    // joined words, one stream per pair
    output merged_word_t                word_o     [`HBM_NUM_PAIRS],
    input  logic [`HBM_NUM_PAIRS-1:0]   credit_i,
    output logic [`HBM_NUM_PAIRS-1:0]   job_done_o
);

    job_len_t job_len;
    logic     job_start;

    param_capture i_param_capture (
        .hbm_clk        (hbm_clk),
        .hbm_rstn       (hbm_rstn),
        .params_valid_i (params_valid_i),
        .params_i       (params_i),
        .job_len_o      (job_len),
        .job_start_o    (job_start)
    );

    ////////////////////
    // per pair: even fifo, odd fifo, joiner
    for (genvar p = 0; p < `HBM_NUM_PAIRS; p++) begin : g_pair
        logic     empty_even;
        logic     empty_odd;
        logic     pop;
        rd_beat_t beat_even;
        rd_beat_t beat_odd;

        channel_fifo i_fifo_even (
            .hbm_clk  (hbm_clk),
            .hbm_rstn (hbm_rstn),
            .beat_i   (rd_beat_i[2*p]),
            .ready_o  (rd_ready_o[2*p]),
            .pop_i    (pop),
            .dout_o   (beat_even),
            .empty_o  (empty_even)
        );

        channel_fifo i_fifo_odd (
            .hbm_clk  (hbm_clk),
            .hbm_rstn (hbm_rstn),
            .beat_i   (rd_beat_i[2*p+1]),
            .ready_o  (rd_ready_o[2*p+1]),
            .pop_i    (pop),                // popped together
            .dout_o   (beat_odd),
            .empty_o  (empty_odd)
        );

        pair_joiner i_pair_joiner (
            .hbm_clk      (hbm_clk),
            .hbm_rstn     (hbm_rstn),
            .job_start_i  (job_start),
            .job_len_i    (job_len),
            .empty_even_i (empty_even),
            .empty_odd_i  (empty_odd),
            .pop_o        (pop),
            .beat_even_i  (beat_even),
            .beat_odd_i   (beat_odd),
            .credit_i     (credit_i[p]),
            .word_o       (word_o[p]),
            .job_done_o   (job_done_o[p])
        );
    end

endmodule

`default_nettype wire

// ==== rtl/pair_joiner.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hbm_merge_cfg.svh"

module pair_joiner
    import hbm_merge_pkg::*;
(
    input  logic         hbm_clk,
    input  logic         hbm_rstn,

    // job setup
    input  logic         job_start_i,
    input  job_len_t     job_len_i,

    // both fifos of the pair
    input  logic         empty_even_i,
    input  logic         empty_odd_i,
    output logic         pop_o,             // same pop to both
    input  rd_beat_t     beat_even_i,
    input  rd_beat_t     beat_odd_i,

    // downstream, credit based
    input  logic         credit_i,          // one slot back per pulse
    output merged_word_t word_o,
    output logic         job_done_o
);

    localparam int CRED_W = $clog2(`HBM_CREDITS) + 1;
    localparam logic [CRED_W-1:0] CRED_MAX = CRED_W'(`HBM_CREDITS);

    logic [CRED_W-1:0]      credit_cnt;
    logic                   job_active;
    job_len_t               pop_cnt;        // words issued this job
    logic                   last_pop;
    logic                   last_q1;        // last flag beside the fifo read reg
    logic                   word_valid_q;
    logic                   word_last_q;
    logic                   done_q;
    logic [`HBM_WORD_W-1:0] word_data_q;

    ////////////////////
    // joint pop, needs data on both sides and a free slot downstream
    assign pop_o    = job_active & ~empty_even_i & ~empty_odd_i & (credit_cnt != '0);
    assign last_pop = pop_o & (pop_cnt == job_len_i - 1'b1);

    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            job_active <= 1'b0;
            pop_cnt    <= '0;
        end else if (job_start_i) begin
            job_active <= (job_len_i != '0);    // empty job never starts
            pop_cnt    <= '0;
        end else if (pop_o) begin
            pop_cnt <= pop_cnt + 1'b1;
            if (last_pop) begin
                job_active <= 1'b0;             // stop before extra beats
            end
        end
    end

    // taken at pop, returned by credit_i
    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            credit_cnt <= CRED_MAX;
        end else begin
            case ({pop_o, credit_i})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;  // cancel out
            endcase
        end
    end

    ////////////////////
    // join register, second stage after pop
    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            last_q1      <= 1'b0;
            word_valid_q <= 1'b0;
            word_last_q  <= 1'b0;
            done_q       <= 1'b0;
        end else begin
            last_q1      <= last_pop;
            word_valid_q <= beat_even_i.valid & beat_odd_i.valid;
            word_last_q  <= last_q1;
            done_q       <= last_q1;            // lines up with last word
        end
    end

    always_ff @(posedge hbm_clk) begin
        if (beat_even_i.valid) begin
            word_data_q <= {beat_odd_i.data, beat_even_i.data};
        end
    end

    assign word_o.valid = word_valid_q;
    assign word_o.last  = word_last_q;
    assign word_o.data  = word_data_q;
    assign job_done_o   = done_q;

endmodule

`default_nettype wire

// ==== rtl/channel_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hbm_merge_cfg.svh"

module channel_fifo
    import hbm_merge_pkg::*;
(
    input  logic     hbm_clk,
    input  logic     hbm_rstn,

    // write side, from the hbm read channel
    input  rd_beat_t beat_i,
    output logic     ready_o,

    // read side, towards the joiner
    input  logic     pop_i,
    output rd_beat_t dout_o,
    output logic     empty_o
);

    localparam int DEPTH = 1 << `HBM_FIFO_DEPTH_BITS;
    localparam logic [`HBM_FIFO_DEPTH_BITS:0] AFULL_LVL =
        (`HBM_FIFO_DEPTH_BITS+1)'(DEPTH - `HBM_AFULL_MARGIN);

    logic [`HBM_BEAT_W-1:0]         mem [DEPTH];    // distributed ram
    logic [`HBM_FIFO_DEPTH_BITS-1:0] wr_ptr;
    logic [`HBM_FIFO_DEPTH_BITS-1:0] rd_ptr;
    logic [`HBM_FIFO_DEPTH_BITS:0]   count;         // occupancy
    logic                            almost_full;
    logic                            push;
    logic                            pop;
    logic                            dout_valid_q;
    logic [`HBM_BEAT_W-1:0]          dout_data_q;

    assign almost_full = (count >= AFULL_LVL);
    assign ready_o     = ~almost_full;              // margin covers beats in flight
    assign empty_o     = (count == '0);
    assign push        = beat_i.valid & ready_o;
    assign pop         = pop_i & ~empty_o;          // never read an empty buffer

    ////////////////////
    // pointers and fill level
    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // both or none
            endcase
        end
    end

    always_ff @(posedge hbm_clk) begin
        if (push) begin
            mem[wr_ptr] <= beat_i.data;
        end
    end

    ////////////////////
    // output register, one cycle after pop
    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            dout_valid_q <= 1'b0;
        end else begin
            dout_valid_q <= pop;
        end
    end

    always_ff @(posedge hbm_clk) begin
        if (pop) begin
            dout_data_q <= mem[rd_ptr];
        end
    end

    assign dout_o.valid = dout_valid_q;
    assign dout_o.data  = dout_data_q;

endmodule

`default_nettype wire

// ==== rtl/param_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "hbm_merge_cfg.svh"

module param_capture
    import hbm_merge_pkg::*;
(
    input  logic        hbm_clk,
    input  logic        hbm_rstn,

    // parameter word, always accepted
    input  logic        params_valid_i,
    input  mlw_params_t params_i,

    // job setup for the pairs
    output job_len_t    job_len_o,
    output logic        job_start_o
);

    // bytes -> 512b words, then split over the pairs
    localparam int PAIR_BITS = $clog2(`HBM_NUM_PAIRS);
    localparam int LEN_SHIFT = `HBM_WORD_BYTES_LOG2 + PAIR_BITS;

    job_len_t words_per_pair;

    assign words_per_pair = params_i.data_a_length >> LEN_SHIFT;

    ////////////////////
    // capture on valid, length held until next word
    always_ff @(posedge hbm_clk) begin
        if (!hbm_rstn) begin
            job_len_o   <= '0;
            job_start_o <= 1'b0;
        end else begin
            job_start_o <= params_valid_i;          // one cycle pulse
            if (params_valid_i) begin
                job_len_o <= words_per_pair;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/hbm_merge_pkg.sv ====
`default_nettype none

`include "hbm_merge_cfg.svh"

package hbm_merge_pkg;

    ////////////////////
    // parameter word, addr_a sits in the low bits
    typedef struct packed {
        logic [31:0] reserved;
        logic [31:0] channel_choice;
        logic [31:0] array_length;
        logic [31:0] data_a_length;     // bytes of A data for the job
        logic [31:0] number_of_bits;
        logic [31:0] number_of_samples;
        logic [31:0] dimension;
        logic [31:0] number_of_epochs;
        logic [31:0] step_size;
        logic [31:0] mini_batch_size;
        logic [63:0] addr_model;
        logic [63:0] addr_b;
        logic [63:0] addr_a;
    } mlw_params_t;

    ////////////////////
    // read response side
    typedef struct packed {
        logic                   valid;
        logic [`HBM_BEAT_W-1:0] data;
    } rd_beat_t;

    typedef struct packed {
        logic                   valid;
        logic                   last;   // final word of the job
        logic [`HBM_WORD_W-1:0] data;   // {odd ch, even ch}
    } merged_word_t;

    typedef logic [31:0] job_len_t;     // joined words per pair

endpackage

`default_nettype wire

// ==== rtl/hbm_merge_cfg.svh ====
`ifndef HBM_MERGE_CFG_SVH
`define HBM_MERGE_CFG_SVH

// datapath widths
`define HBM_BEAT_W          256     // one read beat per channel
`define HBM_WORD_W          512     // two beats joined

// channel layout
`define HBM_NUM_PAIRS       2       // 4 read channels

// per channel read buffer
`define HBM_FIFO_DEPTH_BITS 6       // 64 entries
`define HBM_AFULL_MARGIN    4       // free slots left at almost-full

// downstream flow control
`define HBM_CREDITS         8       // buffer slots per pair downstream
`define HBM_WORD_BYTES_LOG2 6       // 64 bytes in a joined word

`endif
